// File: cpu_pkg.sv
// cpu package: widths, word types, opcodes, function codes, alu ops, forwarding selects, payloads
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // ********************
    // instruction encoding
    // ********************

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,    // zero, so a cleared ctrl_t decodes as add
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_t;

    // ********************
    // stage payloads
    // ********************

    typedef struct packed {
        logic    reg_write;
        logic    reg_dst;    // rd when set, rt otherwise
        logic    alu_src;    // immediate as operand b
        alu_op_t alu_op;
        logic    mem_write;
        logic    mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t pc_next;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rs_data;
        word_t    rt_data;
        word_t    sign_imm;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    write_data;   // store data, already forwarded
        reg_idx_t write_reg;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    read_data;
        reg_idx_t write_reg;
    } mem_wb_t;

endpackage

// File: cpu_top.sv
`timescale 1ns/10ps
// cpu_top: five stage core with border registers, hazard unit and debug register read
module cpu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t reg_addr,
    output cpu_pkg::word_t    reg_data,
    output cpu_pkg::word_t    im_addr,
    input  cpu_pkg::word_t    im_data,
    output cpu_pkg::word_t    dm_addr,
    output logic              dm_we,
    output cpu_pkg::word_t    dm_wdata,
    input  cpu_pkg::word_t    dm_rdata
);
    import cpu_pkg::*;

    word_t    pc_f;
    word_t    pc_next_f;
    word_t    pc_branch_d;
    word_t    instr_d;
    word_t    reg_data0;
    word_t    wb_data;
    reg_idx_t rs_d;
    reg_idx_t rt_d;
    reg_idx_t wb_reg;
    if_id_t   if_id_f;
    if_id_t   if_id_d;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_e;
    ex_mem_t  ex_mem_e;
    ex_mem_t  ex_mem_m;
    fwd_sel_t fwd_a_e;
    fwd_sel_t fwd_b_e;
    logic     fwd_a_d;
    logic     fwd_b_d;
    logic     pc_src_d;
    logic     branch_d;
    logic     stall_n;
    logic     flush_n_d;
    logic     flush_n_e;
    logic     wb_we;

    // ********************
    // F
    // ********************

    fetch_stage fetch0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (stall_n),
        .pc_src    (pc_src_d),
        .pc_branch (pc_branch_d),
        .pc        (pc_f),
        .pc_next   (pc_next_f)
    );

    assign im_addr = pc_f;
    assign if_id_f = '{pc: pc_f, pc_next: pc_next_f};

    stage_reg #(.payload_t(word_t)) r_instr_d (
        .clk (clk), .rst_n (rst_n), .en (stall_n), .flush_n (flush_n_d),
        .d   (im_data), .q (instr_d)
    );

    stage_reg #(.payload_t(if_id_t)) r_if_id (
        .clk (clk), .rst_n (rst_n), .en (stall_n), .flush_n (flush_n_d),
        .d   (if_id_f), .q (if_id_d)
    );

    // ********************
    // D
    // ********************

    decode_stage decode0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr_d),
        .if_id        (if_id_d),
        .fwd_a        (fwd_a_d),
        .fwd_b        (fwd_b_d),
        .alu_result_m (dm_addr),    // M stage ALU result
        .reg_addr     (reg_addr),
        .reg_data0    (reg_data0),
        .wb_we        (wb_we),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .id_ex        (id_ex_d),
        .pc_src       (pc_src_d),
        .pc_branch    (pc_branch_d),
        .rs           (rs_d),
        .rt           (rt_d),
        .branch       (branch_d)
    );

    // register 0 reads back the fetch pc
    assign reg_data = (reg_addr != '0) ? reg_data0 : pc_f;

    stage_reg #(.payload_t(id_ex_t)) r_id_ex (
        .clk (clk), .rst_n (rst_n), .en (1'b1), .flush_n (flush_n_e),
        .d   (id_ex_d), .q (id_ex_e)
    );

    // ********************
    // E, M and W
    // ********************

    execute_stage execute0 (
        .id_ex        (id_ex_e),
        .fwd_a        (fwd_a_e),
        .fwd_b        (fwd_b_e),
        .alu_result_m (dm_addr),
        .wb_data      (wb_data),
        .ex_mem       (ex_mem_e)
    );

    stage_reg #(.payload_t(ex_mem_t)) r_ex_mem (
        .clk (clk), .rst_n (rst_n), .en (1'b1), .flush_n (1'b1),
        .d   (ex_mem_e), .q (ex_mem_m)
    );

    mem_wb_stage mem_wb0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_mem   (ex_mem_m),
        .dm_rdata (dm_rdata),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_we    (dm_we),
        .wb_we    (wb_we),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

    hazard_unit hazard0 (
        .rs_d        (rs_d),
        .rt_d        (rt_d),
        .rs_e        (id_ex_e.rs),
        .rt_e        (id_ex_e.rt),
        .write_reg_e (ex_mem_e.write_reg),
        .write_reg_m (ex_mem_m.write_reg),
        .write_reg_w (wb_reg),
        .ctrl_e      (id_ex_e.ctrl),
        .ctrl_m      (ex_mem_m.ctrl),
        .reg_write_w (wb_we),
        .branch_d    (branch_d),
        .pc_src_d    (pc_src_d),
        .fwd_a_e     (fwd_a_e),
        .fwd_b_e     (fwd_b_e),
        .fwd_a_d     (fwd_a_d),
        .fwd_b_d     (fwd_b_d),
        .stall_n     (stall_n),
        .flush_n_e   (flush_n_e),
        .flush_n_d   (flush_n_d)
    );

endmodule

// File: decode_stage.sv
`timescale 1ns/10ps
// decode_stage: field split, control decode, sign extension, branch target and early compare
module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::if_id_t   if_id,
    input  logic              fwd_a,
    input  logic              fwd_b,
    input  cpu_pkg::word_t    alu_result_m,
    input  cpu_pkg::reg_idx_t reg_addr,
    output cpu_pkg::word_t    reg_data0,
    input  logic              wb_we,
    input  cpu_pkg::reg_idx_t wb_reg,
    input  cpu_pkg::word_t    wb_data,
    output cpu_pkg::id_ex_t   id_ex,
    output logic              pc_src,
    output cpu_pkg::word_t    pc_branch,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rt,
    output logic              branch
);
    import cpu_pkg::*;

    logic [5:0]  op;
    logic [5:0]  fn;
    reg_idx_t    rd;
    logic [15:0] imm;
    word_t       sign_imm;
    word_t       rs_data;
    word_t       rt_data;
    word_t       cmp_a;
    word_t       cmp_b;
    logic        is_beq;
    logic        is_bne;
    ctrl_t       ctrl;

    // instruction fields
    assign op  = instr[31:26];
    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign rd  = instr[15:11];
    assign fn  = instr[5:0];
    assign imm = instr[15:0];

    reg_file rf0 (
        .clk   (clk),
        .rst_n (rst_n),
        .a0    (reg_addr),
        .a1    (rs),
        .a2    (rt),
        .rd0   (reg_data0),
        .rd1   (rs_data),
        .rd2   (rt_data),
        .we    (wb_we),
        .a3    (wb_reg),
        .wd    (wb_data)
    );

    assign sign_imm  = {{16{imm[15]}}, imm};
    assign pc_branch = if_id.pc_next + sign_imm;    // no delay slot

    // ********************
    // early branch compare
    // ********************

    assign cmp_a  = fwd_a ? alu_result_m : rs_data;
    assign cmp_b  = fwd_b ? alu_result_m : rt_data;
    assign pc_src = (is_beq && cmp_a == cmp_b) || (is_bne && cmp_a != cmp_b);
    assign branch = is_beq | is_bne;

    always_comb begin
        ctrl   = '0;
        is_beq = 1'b0;
        is_bne = 1'b0;
        case (op)
            op_rtype: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (fn)
                    fn_addu: ctrl.alu_op = alu_add;
                    fn_subu: ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    default: ctrl = '0;     // anything else runs as a bubble
                endcase
            end
            op_addiu: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_lui;
            end
            op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            op_sw: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_beq:  is_beq = 1'b1;
            op_bne:  is_bne = 1'b1;
            default: ctrl = '0;
        endcase
    end

    assign id_ex = '{ctrl: ctrl, rs_data: rs_data, rt_data: rt_data, sign_imm: sign_imm,
                     rs: rs, rt: rt, rd: rd};

endmodule

// File: execute_stage.sv
`timescale 1ns/10ps
// execute_stage: operand forwarding, operand b select, alu and destination register select
module execute_stage (
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    input  cpu_pkg::word_t    alu_result_m,
    input  cpu_pkg::word_t    wb_data,
    output cpu_pkg::ex_mem_t  ex_mem
);
    import cpu_pkg::*;

    word_t    src_a;
    word_t    src_b;
    word_t    write_data;
    word_t    alu_result;
    reg_idx_t write_reg;

    function automatic word_t fwd_pick(
        fwd_sel_t sel,
        word_t    reg_val,
        word_t    mem_val,
        word_t    wb_val
    );
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a      = fwd_pick(fwd_a, id_ex.rs_data, alu_result_m, wb_data);
    assign write_data = fwd_pick(fwd_b, id_ex.rt_data, alu_result_m, wb_data);
    assign src_b      = id_ex.ctrl.alu_src ? id_ex.sign_imm : write_data;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add: alu_result = src_a + src_b;
            alu_sub: alu_result = src_a - src_b;
            alu_and: alu_result = src_a & src_b;
            alu_or:  alu_result = src_a | src_b;
            alu_slt: alu_result = {{(xlen - 1){1'b0}}, $signed(src_a) < $signed(src_b)};
            alu_lui: alu_result = {src_b[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    assign write_reg = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

    assign ex_mem = '{ctrl: id_ex.ctrl, alu_result: alu_result, write_data: write_data,
                      write_reg: write_reg};

endmodule

// File: fetch_stage.sv
`timescale 1ns/10ps
// fetch_stage: program counter with branch or sequential next-pc selection
module fetch_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           en,          // low while decode stalls
    input  logic           pc_src,      // taken branch in decode
    input  cpu_pkg::word_t pc_branch,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t pc_next
);

    // word addressed, one instruction per step
    assign pc_next = pc + 1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (en) begin
            pc <= pc_src ? pc_branch : pc_next;
        end
    end

endmodule

// File: hazard_unit.sv
`timescale 1ns/10ps
// hazard_unit: forwarding selects, load-use and branch stalls, decode flush
module hazard_unit (
    input  cpu_pkg::reg_idx_t rs_d,
    input  cpu_pkg::reg_idx_t rt_d,
    input  cpu_pkg::reg_idx_t rs_e,
    input  cpu_pkg::reg_idx_t rt_e,
    input  cpu_pkg::reg_idx_t write_reg_e,
    input  cpu_pkg::reg_idx_t write_reg_m,
    input  cpu_pkg::reg_idx_t write_reg_w,
    input  cpu_pkg::ctrl_t    ctrl_e,
    input  cpu_pkg::ctrl_t    ctrl_m,
    input  logic              reg_write_w,
    input  logic              branch_d,
    input  logic              pc_src_d,
    output cpu_pkg::fwd_sel_t fwd_a_e,
    output cpu_pkg::fwd_sel_t fwd_b_e,
    output logic              fwd_a_d,
    output logic              fwd_b_d,
    output logic              stall_n,
    output logic              flush_n_e,
    output logic              flush_n_d
);
    import cpu_pkg::*;

    logic lw_stall;
    logic branch_stall;
    logic stall;

    // the younger producer in M wins over W
    function automatic fwd_sel_t fwd_pick(
        reg_idx_t src,
        reg_idx_t dst_m,
        logic     we_m,
        reg_idx_t dst_w,
        logic     we_w
    );
        if (src == '0) begin
            return fwd_none;
        end else if (we_m && src == dst_m) begin
            return fwd_mem;
        end else if (we_w && src == dst_w) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign fwd_a_e = fwd_pick(rs_e, write_reg_m, ctrl_m.reg_write, write_reg_w, reg_write_w);
    assign fwd_b_e = fwd_pick(rt_e, write_reg_m, ctrl_m.reg_write, write_reg_w, reg_write_w);

    // branch comparator only takes ALU results from M
    assign fwd_a_d = (rs_d != '0) && (rs_d == write_reg_m) && ctrl_m.reg_write;
    assign fwd_b_d = (rt_d != '0) && (rt_d == write_reg_m) && ctrl_m.reg_write;

    assign lw_stall = ctrl_e.mem_to_reg && (rs_d == write_reg_e || rt_d == write_reg_e);

    assign branch_stall = branch_d &&
        ((ctrl_e.reg_write && (rs_d == write_reg_e || rt_d == write_reg_e)) ||
         (ctrl_m.mem_to_reg && (rs_d == write_reg_m || rt_d == write_reg_m)));

    assign stall     = lw_stall | branch_stall;
    assign stall_n   = ~stall;
    assign flush_n_e = ~stall;                  // bubble into E while D holds
    assign flush_n_d = ~(pc_src_d & ~stall);    // compare is stale during a stall

endmodule

// File: mem_wb_stage.sv
`timescale 1ns/10ps
// mem_wb_stage: data memory drive, M to W border and writeback select
module mem_wb_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::ex_mem_t  ex_mem,
    input  cpu_pkg::word_t    dm_rdata,
    output cpu_pkg::word_t    dm_addr,
    output cpu_pkg::word_t    dm_wdata,
    output logic              dm_we,
    output logic              wb_we,
    output cpu_pkg::reg_idx_t wb_reg,
    output cpu_pkg::word_t    wb_data
);
    import cpu_pkg::*;

    mem_wb_t mem_wb_m;
    mem_wb_t mem_wb_w;

    assign dm_addr  = ex_mem.alu_result;
    assign dm_wdata = ex_mem.write_data;
    assign dm_we    = ex_mem.ctrl.mem_write;

    // only loads capture the read port, other addresses may be unmapped
    assign mem_wb_m = '{ctrl: ex_mem.ctrl, alu_result: ex_mem.alu_result,
                        read_data: ex_mem.ctrl.mem_to_reg ? dm_rdata : '0,
                        write_reg: ex_mem.write_reg};

    stage_reg #(.payload_t(mem_wb_t)) r_mem_wb (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (1'b1),
        .flush_n (1'b1),
        .d       (mem_wb_m),
        .q       (mem_wb_w)
    );

    assign wb_we   = mem_wb_w.ctrl.reg_write;
    assign wb_reg  = mem_wb_w.write_reg;
    assign wb_data = mem_wb_w.ctrl.mem_to_reg ? mem_wb_w.read_data : mem_wb_w.alu_result;

endmodule

// File: pipeline_vectors.txt
# I word_address instruction   S store_address store_data   (all hex)
# R register expected_value    H address_of_final_self_branch
I 00 24010010
I 01 3c021234
I 02 24425678
I 03 2403fffd
I 04 00432021
I 05 00812823
I 06 00a23024
I 07 00c33825
I 08 0061402a
I 09 0023482a
I 0a ac240000
I 0b ac270001
I 0c 240a0055
I 0d ac2a0002
I 0e 8c2b0000
I 0f 016b6021
I 10 8c2d0002
I 11 11aa0001
I 12 240e00bb
I 13 15a10001
I 14 240f00cc
I 15 154d0001
I 16 241000dd
I 17 020c8821
I 18 022c9023
I 19 12500001
I 1a 241300ee
I 1b ac320003
I 1c ac2c0004
I 1d 1000ffff
S 10 12345675
S 11 fffffffd
S 12 00000055
S 13 000000dd
S 14 2468acea
R 01 00000010
R 02 12345678
R 03 fffffffd
R 04 12345675
R 05 12345665
R 06 12345660
R 07 fffffffd
R 08 00000001
R 09 00000000
R 0a 00000055
R 0b 12345675
R 0c 2468acea
R 0d 00000055
R 0e 00000000
R 0f 00000000
R 10 000000dd
R 11 2468adc7
R 12 000000dd
R 13 00000000
H 1d 00000000

// File: reg_file.sv
`timescale 1ns/10ps
// reg_file: 32x32 registers, two decode read ports, a debug read port, falling edge write
module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t a0,
    input  cpu_pkg::reg_idx_t a1,
    input  cpu_pkg::reg_idx_t a2,
    output cpu_pkg::word_t    rd0,
    output cpu_pkg::word_t    rd1,
    output cpu_pkg::word_t    rd2,
    input  logic              we,
    input  cpu_pkg::reg_idx_t a3,
    input  cpu_pkg::word_t    wd
);
    import cpu_pkg::*;

    word_t regs [32];

    // write half a cycle early so decode sees it in the same cycle
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && a3 != '0) begin
            regs[a3] <= wd;
        end
    end

    assign rd0 = (a0 == '0) ? '0 : regs[a0];
    assign rd1 = (a1 == '0) ? '0 : regs[a1];
    assign rd2 = (a2 == '0) ? '0 : regs[a2];

    // writeback data comes from the W border and the data memory
    a_wd_known : assert property (@(negedge clk) disable iff (!rst_n) we |-> !$isunknown(wd))
        else $error("reg_file: unknown write data");

endmodule

// File: sim.f
cpu_pkg.sv
stage_reg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
hazard_unit.sv
cpu_top.sv
tb_cpu.sv

// File: stage_reg.sv
`timescale 1ns/10ps
// stage_reg: pipeline border register with payload type, load enable and synchronous flush
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     flush_n,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (!flush_n) begin
            q <= '0;        // bubble, wins over hold
        end else if (en) begin
            q <= d;
        end
    end

    // upstream stages must never hand an unknown payload across a border
    a_q_known : assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(q))
        else $error("stage_reg: unknown payload after reset");

endmodule

// File: tb_cpu.sv
`timescale 1ns/10ps
// tb_cpu: clock, reset, instruction and data memory models, vector reader, store and register checks
module tb_cpu;
    import cpu_pkg::*;

    localparam int mem_depth    = 256;
    localparam int halt_timeout = 1000;    // cycles

    logic     clk;
    logic     rst_n;
    reg_idx_t reg_addr;
    word_t    reg_data;
    word_t    im_addr;
    word_t    im_data;
    word_t    dm_addr;
    logic     dm_we;
    word_t    dm_wdata;
    word_t    dm_rdata;

    word_t imem [mem_depth];
    word_t dmem [mem_depth];

    word_t st_addr_q [$];    // expected stores, program order
    word_t st_data_q [$];
    word_t r_idx_q [$];      // expected final registers
    word_t r_val_q [$];
    word_t halt_addr;
    int    st_seen;
    integer seed;

    cpu_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ********************
    // memory models
    // ********************

    assign im_data  = (im_addr < mem_depth) ? imem[im_addr] : '0;    // unmapped reads as nop
    assign dm_rdata = (dm_addr < mem_depth) ? dmem[dm_addr] : '0;

    always @(posedge clk) begin
        if (dm_we === 1'b1 && dm_addr < mem_depth) begin
            dmem[dm_addr] <= dm_wdata;
        end
    end

    // ********************
    // checks
    // ********************

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    // each store is in M for exactly one cycle
    always @(negedge clk) begin
        if (rst_n === 1'b1 && dm_we === 1'b1) begin
            if (st_seen >= st_addr_q.size()) begin
                abort_run("a store appeared after all expected stores were seen");
            end else begin
                check_value("dm_addr", dm_addr, st_addr_q[st_seen]);
                check_value("dm_wdata", dm_wdata, st_data_q[st_seen]);
                st_seen++;
            end
        end
    end

    task automatic fill_memories();
        seed = 32'h3750;
        for (int i = 0; i < mem_depth; i++) begin
            imem[i] = '0;
            dmem[i] = $random(seed);    // loads only read words the program wrote
        end
    endtask

    task automatic read_vectors();
        integer fd;
        integer code;
        logic [7:0] tag;
        logic [8*128-1:0] rest;
        word_t f0;
        word_t f1;
        fd = $fopen("pipeline_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open pipeline_vectors.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(rest, fd);    // comment line
                end else begin
                    code = $fscanf(fd, "%h %h", f0, f1);
                    if (code != 2) begin
                        abort_run("a vector line is missing its two hex fields");
                    end
                    case (tag)
                        "I": imem[f0] = f1;
                        "S": begin
                            st_addr_q.push_back(f0);
                            st_data_q.push_back(f1);
                        end
                        "R": begin
                            r_idx_q.push_back(f0);
                            r_val_q.push_back(f1);
                        end
                        "H": halt_addr = f0;
                        default: abort_run("unknown tag in the vector file");
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (im_addr !== halt_addr) begin
            if (cycles == halt_timeout) begin
                abort_run("fetch never reached the final self-branch");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic check_debug_pc();
        @(posedge clk);
        reg_addr <= '0;
        @(negedge clk);
        // self-branch leaves fetch on H or on the flushed H+1
        if (reg_data !== halt_addr) begin
            check_value("reg_data[0]", reg_data, halt_addr + 1);
        end
    endtask

    task automatic check_registers();
        for (int i = 0; i < r_idx_q.size(); i++) begin
            @(posedge clk);
            reg_addr <= r_idx_q[i][4:0];
            @(negedge clk);
            check_value($sformatf("reg_data[%0d]", r_idx_q[i]), reg_data, r_val_q[i]);
        end
    endtask

    // ********************
    // main sequence
    // ********************

    initial begin
        rst_n     = 1'b0;
        reg_addr  = '0;
        st_seen   = 0;
        halt_addr = '0;
        fill_memories();
        read_vectors();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait_for_halt();
        repeat (10) @(posedge clk);    // drain the last stores
        check_debug_pc();
        check_registers();
        check_value("store count", st_seen, st_addr_q.size());
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
